// ==== compile.f ====
verilog/mdio_pkg.sv
verilog/mdc_clock_gen.sv
verilog/mdio_frame_engine.sv
verilog/mdio_init_sequencer.sv
verilog/mdio_master_top.sv
dv/mdio_phy_model.sv
dv/tb_mdio_master.sv

// ==== dv/tb_mdio_master.sv ====
`timescale 1ns/1ps

module tb_mdio_master
    import mdio_pkg::*;
();

    localparam logic [MDIO_PHY_ADDR_W-1:0] MODEL_PHY = 5'd1;
    localparam int FRAME_CLKS = (PREAMBLE_BITS + FRAME_BITS) * 2 * CLKS_PER_HALF_MDC;
    localparam int TIMEOUT_CYCLES = 12 * FRAME_CLKS + 1000;

    logic                       clk;
    logic                       reset;
    logic                       req;
    logic                       req_write;
    logic [MDIO_PHY_ADDR_W-1:0] req_phy;
    logic [MDIO_REG_ADDR_W-1:0] req_reg;
    logic [MDIO_DATA_W-1:0]     req_wdata;
    logic                       busy;
    logic                       rd_valid;
    logic [MDIO_DATA_W-1:0]     rd_data;
    logic                       init_done;
    logic                       mdc;
    logic                       mdio_out;
    logic                       mdio_t;
    logic                       mdio_line;
    logic                       phy_drive;
    logic                       phy_oe;
    int                         frame_count;
    int                         format_errors;

    logic [31:0] lfsr = 32'h1d8a09d0;
    int          errors = 0;
    int          cycles = 0;
    int          host_accepts;
    logic        mdc_prev;
    int          half_len;
    int          lead_ones = 0;
    logic        in_lead = 1'b1;

    // Master, then model, then the pull-up
    assign mdio_line = !mdio_t ? mdio_out : (phy_oe ? phy_drive : 1'b1);

    mdio_master_top u_mdio_master_top (
        .clk         (clk),
        .reset       (reset),
        .req_i       (req),
        .req_write_i (req_write),
        .req_phy_i   (req_phy),
        .req_reg_i   (req_reg),
        .req_wdata_i (req_wdata),
        .busy_o      (busy),
        .rd_valid_o  (rd_valid),
        .rd_data_o   (rd_data),
        .init_done_o (init_done),
        .mdc_o       (mdc),
        .mdio_o      (mdio_out),
        .mdio_t_o    (mdio_t),
        .mdio_i      (mdio_line)
    );

    mdio_phy_model #(.PHY_ADDR(MODEL_PHY)) u_phy_model (
        .mdc_i           (mdc),
        .mdio_i          (mdio_line),
        .mdio_o          (phy_drive),
        .mdio_oe_o       (phy_oe),
        .frame_count_o   (frame_count),
        .format_errors_o (format_errors)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    task automatic take_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic flag_error(input string msg);
        errors++;
        $display("[FAIL] %0t %s", $time, msg);
    endtask

    task automatic send_request(input logic write, input logic [4:0] phy,
                                input logic [4:0] addr, input logic [15:0] data);
        do begin
            @(posedge clk);
        end while (busy);
        req <= 1'b1;
        req_write <= write;
        req_phy <= phy;
        req_reg <= addr;
        req_wdata <= data;
        @(posedge clk);
        req <= 1'b0;
    endtask

    task automatic write_register(input logic [4:0] phy, input logic [4:0] addr,
                                  input logic [15:0] data);
        send_request(1'b1, phy, addr, data);
        do begin
            @(posedge clk);
        end while (busy);
    endtask

    task automatic read_register(input logic [4:0] phy, input logic [4:0] addr,
                                 output logic [15:0] data);
        send_request(1'b0, phy, addr, 16'h0000);
        do begin
            @(posedge clk);
        end while (!rd_valid);
        data = rd_data;
    endtask

    always @(posedge clk) begin
        if (reset) begin
            host_accepts <= 0;
            mdc_prev <= mdc;
            half_len <= 0;
        end else begin
            if (req && !busy) begin
                host_accepts <= host_accepts + 1;
            end
            mdc_prev <= mdc;
            half_len <= (mdc != mdc_prev) ? 1 : half_len + 1;
        end
    end

    // Length of the run of driven ones before the start bit
    always @(posedge mdc) begin
        if (reset || mdio_t) begin
            lead_ones = 0;
            in_lead = 1'b1;
        end else if (in_lead) begin
            if (mdio_out) begin
                lead_ones++;
            end else begin
                assert (lead_ones == PREAMBLE_BITS)
                    else flag_error($sformatf("preamble had %0d ones", lead_ones));
                in_lead = 1'b0;
            end
        end
    end

    a_mdc_half_period: assert property (
        @(posedge clk) disable iff (reset)
        (mdc != mdc_prev) |-> (half_len == CLKS_PER_HALF_MDC)
    ) else flag_error($sformatf("MDC half period of %0d clk", half_len));

    a_mdio_after_fall: assert property (
        @(posedge clk) disable iff (reset)
        ($changed(mdio_out) || $changed(mdio_t)) |-> $past(mdc_prev && !mdc)
    ) else flag_error("MDIO changed outside the clk after an MDC fall");

    a_no_contention: assert property (
        @(posedge clk) disable iff (reset)
        !(phy_oe && !mdio_t)
    ) else flag_error("master and PHY drive MDIO together");

    a_frame_format: assert property (
        @(posedge clk) disable iff (reset)
        $stable(format_errors)
    ) else flag_error("PHY saw a bad preamble, start, opcode or turnaround");

    a_init_done_holds: assert property (
        @(posedge clk) disable iff (reset)
        init_done |=> init_done
    ) else flag_error("init_done dropped");

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        logic [31:0]                rnd;
        logic [MDIO_REG_ADDR_W-1:0] addr;
        logic [MDIO_PHY_ADDR_W-1:0] other_phy;
        logic [MDIO_DATA_W-1:0]     wdata;
        logic [MDIO_DATA_W-1:0]     rdata;
        logic [MDIO_DATA_W-1:0]     snapshot [32];

        reset = 1'b1;
        req = 1'b0;
        req_write = 1'b0;
        req_phy = '0;
        req_reg = '0;
        req_wdata = '0;

        repeat (3) @(posedge clk);
        reset <= 1'b0;

        @(posedge clk);
        assert (!mdc && mdio_t && !rd_valid && !init_done && busy)
            else flag_error("outputs after reset not at idle values");

        do begin
            @(posedge clk);
        end while (!init_done);
        assert (frame_count == INIT_COUNT)
            else flag_error($sformatf("init_done after %0d frames", frame_count));
        for (int i = 0; i < INIT_COUNT; i++) begin
            assert (u_phy_model.regs[INIT_REG[i]] == INIT_DATA[i])
                else flag_error($sformatf("init reg %h holds %h", INIT_REG[i],
                                          u_phy_model.regs[INIT_REG[i]]));
        end

        // Write then read back on the model's PHY
        repeat (3) begin
            take_bits(5, rnd);
            addr = rnd[4:0];
            take_bits(16, rnd);
            wdata = rnd[15:0];
            write_register(MODEL_PHY, addr, wdata);
            assert (u_phy_model.regs[addr] == wdata)
                else flag_error($sformatf("PHY reg %h holds %h, wrote %h", addr,
                                          u_phy_model.regs[addr], wdata));
            read_register(MODEL_PHY, addr, rdata);
            assert (rdata == wdata)
                else flag_error($sformatf("read reg %h got %h expected %h", addr, rdata, wdata));
        end

        // Nobody answers, the pull-up gives all ones
        take_bits(5, rnd);
        other_phy = rnd[4:0];
        if (other_phy == MODEL_PHY) begin
            other_phy = ~other_phy;
        end
        take_bits(5, rnd);
        addr = rnd[4:0];
        for (int i = 0; i < 32; i++) begin
            snapshot[i] = u_phy_model.regs[i];
        end
        read_register(other_phy, addr, rdata);
        assert (rdata == 16'hffff)
            else flag_error($sformatf("read of PHY %h got %h expected ffff", other_phy, rdata));
        for (int i = 0; i < 32; i++) begin
            assert (u_phy_model.regs[i] == snapshot[i])
                else flag_error($sformatf("PHY reg %h changed by a foreign read", i));
        end

        // Second strobe lands while busy and must be dropped
        take_bits(5, rnd);
        addr = rnd[4:0];
        take_bits(16, rnd);
        wdata = rnd[15:0];
        send_request(1'b1, MODEL_PHY, addr, wdata);
        @(posedge clk);
        assert (busy) else flag_error("busy not set after an accepted request");
        req <= 1'b1;
        req_wdata <= ~wdata;
        @(posedge clk);
        req <= 1'b0;
        do begin
            @(posedge clk);
        end while (busy);
        repeat ((PREAMBLE_BITS + 4) * 2 * CLKS_PER_HALF_MDC) @(posedge clk);
        assert (u_phy_model.regs[addr] == wdata)
            else flag_error($sformatf("PHY reg %h holds %h expected %h", addr,
                                      u_phy_model.regs[addr], wdata));
        assert (frame_count == INIT_COUNT + host_accepts)
            else flag_error($sformatf("%0d frames seen for %0d accepted requests",
                                      frame_count, host_accepts));

        $display("Summary: %0d frames, %0d errors", frame_count, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== dv/mdio_phy_model.sv ====
`timescale 1ns/1ps

module mdio_phy_model
    import mdio_pkg::*;
#(
    parameter logic [MDIO_PHY_ADDR_W-1:0] PHY_ADDR = 5'd1
) (
    input  var logic mdc_i,
    input  var logic mdio_i,
    output var logic mdio_o,
    output var logic mdio_oe_o,
    output var int   frame_count_o,
    output var int   format_errors_o
);

    logic [MDIO_DATA_W-1:0]     regs [32];
    int                         ones;
    int                         pos;
    logic [12:0]                header;
    logic [1:0]                 ta;
    logic [MDIO_DATA_W-1:0]     shift_in;
    logic [MDIO_DATA_W-1:0]     rd_word;
    logic [MDIO_REG_ADDR_W-1:0] reg_addr;
    logic                       is_write;
    logic                       for_us;

    initial begin
        for (int i = 0; i < 32; i++) begin
            regs[i] = {3'b101, i[4:0], 3'b010, i[4:0]};
        end
        ones = 0;
        pos = -1;
        is_write = 1'b0;
        for_us = 1'b0;
        mdio_o = 1'b1;
        mdio_oe_o = 1'b0;
        frame_count_o = 0;
        format_errors_o = 0;
    end

    // Frame decode, pos is the index of the bit after the preamble
    always @(posedge mdc_i) begin
        if (pos < 0) begin
            if (mdio_i) begin
                if (ones < PREAMBLE_BITS) begin
                    ones++;
                end
            end else begin
                if (ones < PREAMBLE_BITS) begin
                    format_errors_o++;
                end
                frame_count_o++;
                ones = 0;
                header = '0;
                pos = 1;
            end
        end else begin
            if (pos < FRAME_TA_BIT) begin
                header = {header[11:0], mdio_i};
            end else if (pos < FRAME_DATA_BIT) begin
                ta = {ta[0], mdio_i};
            end else begin
                shift_in = {shift_in[MDIO_DATA_W-2:0], mdio_i};
            end

            // Second start bit, opcode, PHY and register are all in
            if (pos == FRAME_TA_BIT - 1) begin
                is_write = (header[11:10] == OP_WRITE);
                for_us = (header[9:5] == PHY_ADDR);
                reg_addr = header[4:0];
                rd_word = regs[header[4:0]];
                if (!header[12] || (header[11:10] != OP_WRITE && header[11:10] != OP_READ)) begin
                    format_errors_o++;
                end
            end

            if (pos == FRAME_DATA_BIT - 1 && is_write && ta != TA_WRITE) begin
                format_errors_o++;
            end

            if (pos == FRAME_BITS - 1) begin
                if (is_write && for_us) begin
                    regs[reg_addr] = shift_in;
                end
                pos = -1;
            end else begin
                pos++;
            end
        end
    end

    // Read answer changes on MDC falls so it is stable at the next rise
    always @(negedge mdc_i) begin
        if (!is_write && for_us && pos > FRAME_TA_BIT) begin
            mdio_oe_o = 1'b1;
            mdio_o = (pos == FRAME_TA_BIT + 1) ? 1'b0 : rd_word[FRAME_BITS - 1 - pos];
        end else begin
            mdio_oe_o = 1'b0;
            mdio_o = 1'b1;
        end
    end

endmodule

// ==== verilog/mdio_master_top.sv ====
`timescale 1ns/1ps

module mdio_master_top
    import mdio_pkg::*;
(
    input  var logic                       clk,
    input  var logic                       reset,

    // Host side
    input  var logic                       req_i,
    input  var logic                       req_write_i,
    input  var logic [MDIO_PHY_ADDR_W-1:0] req_phy_i,
    input  var logic [MDIO_REG_ADDR_W-1:0] req_reg_i,
    input  var logic [MDIO_DATA_W-1:0]     req_wdata_i,
    output var logic                       busy_o,
    output var logic                       rd_valid_o,
    output var logic [MDIO_DATA_W-1:0]     rd_data_o,
    output var logic                       init_done_o,

    // Pin side
    output var logic                       mdc_o,
    output var logic                       mdio_o,
    output var logic                       mdio_t_o,
    input  var logic                       mdio_i
);

    logic                       mdc_rise;
    logic                       mdc_fall;
    logic                       eng_start;
    logic                       eng_write;
    logic [MDIO_PHY_ADDR_W-1:0] eng_phy;
    logic [MDIO_REG_ADDR_W-1:0] eng_reg;
    logic [MDIO_DATA_W-1:0]     eng_wdata;
    logic                       eng_busy;
    logic                       eng_done;
    logic [MDIO_DATA_W-1:0]     eng_rd_data;

    mdc_clock_gen u_mdc_clock_gen (
        .clk        (clk),
        .reset      (reset),
        .mdc_o      (mdc_o),
        .mdc_rise_o (mdc_rise),
        .mdc_fall_o (mdc_fall)
    );

    mdio_frame_engine u_mdio_frame_engine (
        .clk        (clk),
        .reset      (reset),
        .mdc_rise_i (mdc_rise),
        .mdc_fall_i (mdc_fall),
        .start_i    (eng_start),
        .write_i    (eng_write),
        .phy_i      (eng_phy),
        .reg_i      (eng_reg),
        .wdata_i    (eng_wdata),
        .mdio_i     (mdio_i),
        .mdio_o     (mdio_o),
        .mdio_t_o   (mdio_t_o),
        .busy_o     (eng_busy),
        .done_o     (eng_done),
        .rd_data_o  (eng_rd_data)
    );

    mdio_init_sequencer u_mdio_init_sequencer (
        .clk           (clk),
        .reset         (reset),
        .req_i         (req_i),
        .req_write_i   (req_write_i),
        .req_phy_i     (req_phy_i),
        .req_reg_i     (req_reg_i),
        .req_wdata_i   (req_wdata_i),
        .eng_busy_i    (eng_busy),
        .eng_done_i    (eng_done),
        .eng_rd_data_i (eng_rd_data),
        .eng_start_o   (eng_start),
        .eng_write_o   (eng_write),
        .eng_phy_o     (eng_phy),
        .eng_reg_o     (eng_reg),
        .eng_wdata_o   (eng_wdata),
        .busy_o        (busy_o),
        .rd_valid_o    (rd_valid_o),
        .rd_data_o     (rd_data_o),
        .init_done_o   (init_done_o)
    );

endmodule

// ==== verilog/mdio_init_sequencer.sv ====
`timescale 1ns/1ps

module mdio_init_sequencer
    import mdio_pkg::*;
(
    input  var logic                       clk,
    input  var logic                       reset,

    input  var logic                       req_i,
    input  var logic                       req_write_i,
    input  var logic [MDIO_PHY_ADDR_W-1:0] req_phy_i,
    input  var logic [MDIO_REG_ADDR_W-1:0] req_reg_i,
    input  var logic [MDIO_DATA_W-1:0]     req_wdata_i,

    input  var logic                       eng_busy_i,
    input  var logic                       eng_done_i,
    input  var logic [MDIO_DATA_W-1:0]     eng_rd_data_i,

    output var logic                       eng_start_o,
    output var logic                       eng_write_o,
    output var logic [MDIO_PHY_ADDR_W-1:0] eng_phy_o,
    output var logic [MDIO_REG_ADDR_W-1:0] eng_reg_o,
    output var logic [MDIO_DATA_W-1:0]     eng_wdata_o,

    output var logic                       busy_o,
    output var logic                       rd_valid_o,
    output var logic [MDIO_DATA_W-1:0]     rd_data_o,
    output var logic                       init_done_o
);

    typedef enum logic [1:0] {
        SQ_INIT_ISSUE,
        SQ_INIT_WAIT,
        SQ_IDLE,
        SQ_HOST_WAIT
    } seq_state_t;

    seq_state_t                      state;
    logic [$clog2(INIT_COUNT)-1:0]   init_idx;
    logic                            host_accept;

    // Requests during busy are simply dropped
    assign host_accept = (state == SQ_IDLE) && req_i && !eng_busy_i;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= SQ_INIT_ISSUE;
            init_idx <= '0;
            eng_start_o <= 1'b0;
            busy_o <= 1'b1;
            rd_valid_o <= 1'b0;
            init_done_o <= 1'b0;
        end else begin
            eng_start_o <= 1'b0;
            rd_valid_o <= 1'b0;

            case (state)
                SQ_INIT_ISSUE: begin
                    eng_start_o <= 1'b1;
                    state <= SQ_INIT_WAIT;
                end

                SQ_INIT_WAIT: begin
                    if (eng_done_i) begin
                        if (init_idx == INIT_COUNT - 1) begin
                            init_done_o <= 1'b1;
                            busy_o <= 1'b0;
                            state <= SQ_IDLE;
                        end else begin
                            init_idx <= init_idx + 1'b1;
                            state <= SQ_INIT_ISSUE;
                        end
                    end
                end

                SQ_IDLE: begin
                    if (host_accept) begin
                        eng_start_o <= 1'b1;
                        busy_o <= 1'b1;
                        state <= SQ_HOST_WAIT;
                    end
                end

                SQ_HOST_WAIT: begin
                    if (eng_done_i) begin
                        busy_o <= 1'b0;
                        // Fields are held, so the write flag still describes this frame
                        rd_valid_o <= !eng_write_o;
                        state <= SQ_IDLE;
                    end
                end

                default: begin
                    state <= SQ_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == SQ_INIT_ISSUE) begin
            eng_write_o <= 1'b1;
            eng_phy_o <= INIT_PHY[init_idx];
            eng_reg_o <= INIT_REG[init_idx];
            eng_wdata_o <= INIT_DATA[init_idx];
        end else if (host_accept) begin
            eng_write_o <= req_write_i;
            eng_phy_o <= req_phy_i;
            eng_reg_o <= req_reg_i;
            eng_wdata_o <= req_wdata_i;
        end

        if (state == SQ_HOST_WAIT && eng_done_i) begin
            rd_data_o <= eng_rd_data_i;
        end
    end

    a_rd_valid_after_read: assert property (
        @(posedge clk) disable iff (reset)
        rd_valid_o |-> $past(eng_done_i) && !eng_write_o && init_done_o
    );

endmodule

// ==== verilog/mdio_frame_engine.sv ====
`timescale 1ns/1ps

module mdio_frame_engine
    import mdio_pkg::*;
(
    input  var logic                       clk,
    input  var logic                       reset,

    input  var logic                       mdc_rise_i,
    input  var logic                       mdc_fall_i,

    input  var logic                       start_i,
    input  var logic                       write_i,
    input  var logic [MDIO_PHY_ADDR_W-1:0] phy_i,
    input  var logic [MDIO_REG_ADDR_W-1:0] reg_i,
    input  var logic [MDIO_DATA_W-1:0]     wdata_i,

    // Discrete MDIO signals, the pad sits above this level
    input  var logic                       mdio_i,
    output var logic                       mdio_o,
    output var logic                       mdio_t_o,

    output var logic                       busy_o,
    output var logic                       done_o,
    output var logic [MDIO_DATA_W-1:0]     rd_data_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ARMED,
        ST_PREAMBLE,
        ST_FRAME
    } phase_t;

    phase_t                                      phase;
    logic [$clog2(PREAMBLE_BITS + FRAME_BITS)-1:0] bit_cnt;
    logic [FRAME_BITS-1:0]                       frame_sr;
    logic                                        write_q;
    logic                                        load_frame;
    logic                                        shift_frame;
    logic                                        sample_data;

    assign load_frame = (phase == ST_IDLE) && start_i;

    // Top bit of the shift register goes out on every fall once the header starts
    assign shift_frame = mdc_fall_i &&
        ((phase == ST_FRAME) ||
         (phase == ST_PREAMBLE && bit_cnt == PREAMBLE_BITS - 1));

    assign sample_data = mdc_rise_i && (phase == ST_FRAME) && !write_q &&
        (bit_cnt >= FRAME_DATA_BIT);

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= ST_IDLE;
            bit_cnt <= '0;
            mdio_o <= 1'b1;
            mdio_t_o <= 1'b1;
            busy_o <= 1'b0;
            done_o <= 1'b0;
        end else begin
            done_o <= 1'b0;

            case (phase)
                ST_IDLE: begin
                    if (start_i) begin
                        busy_o <= 1'b1;
                        phase <= ST_ARMED;
                    end
                end

                // Wait for the next MDC fall before the first preamble bit
                ST_ARMED: begin
                    if (mdc_fall_i) begin
                        mdio_o <= 1'b1;
                        mdio_t_o <= 1'b0;
                        bit_cnt <= '0;
                        phase <= ST_PREAMBLE;
                    end
                end

                ST_PREAMBLE: begin
                    if (mdc_fall_i) begin
                        if (bit_cnt == PREAMBLE_BITS - 1) begin
                            mdio_o <= frame_sr[FRAME_BITS-1];
                            bit_cnt <= '0;
                            phase <= ST_FRAME;
                        end else begin
                            mdio_o <= 1'b1;
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end

                ST_FRAME: begin
                    if (mdc_fall_i) begin
                        if (bit_cnt == FRAME_BITS - 1) begin
                            // Last data bit ends here
                            done_o <= 1'b1;
                            busy_o <= 1'b0;
                            mdio_o <= 1'b1;
                            mdio_t_o <= 1'b1;
                            phase <= ST_IDLE;
                        end else begin
                            mdio_o <= frame_sr[FRAME_BITS-1];
                            // Reads release the line from the first turnaround bit on
                            mdio_t_o <= !write_q && (bit_cnt + 1 >= FRAME_TA_BIT);
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end

                default: begin
                    phase <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load_frame) begin
            frame_sr <= {
                FRAME_START,
                write_i ? OP_WRITE : OP_READ,
                phy_i,
                reg_i,
                write_i ? TA_WRITE : TA_READ,
                write_i ? wdata_i : {MDIO_DATA_W{1'b1}}
            };
            write_q <= write_i;
        end else if (shift_frame) begin
            frame_sr <= {frame_sr[FRAME_BITS-2:0], 1'b0};
        end

        if (sample_data) begin
            rd_data_o <= {rd_data_o[MDIO_DATA_W-2:0], mdio_i};
        end
    end

    a_no_start_while_busy: assert property (
        @(posedge clk) disable iff (reset)
        start_i |-> !busy_o
    );

    a_write_data_driven: assert property (
        @(posedge clk) disable iff (reset)
        (phase == ST_FRAME && write_q && bit_cnt >= FRAME_DATA_BIT) |-> !mdio_t_o
    );

endmodule

// ==== verilog/mdc_clock_gen.sv ====
`timescale 1ns/1ps

module mdc_clock_gen
    import mdio_pkg::*;
(
    input  var logic clk,
    input  var logic reset,

    output var logic mdc_o,
    output var logic mdc_rise_o,
    output var logic mdc_fall_o
);

    logic [$clog2(CLKS_PER_HALF_MDC + 1)-1:0] half_cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            half_cnt <= '0;
            mdc_o <= 1'b0;
            mdc_rise_o <= 1'b0;
            mdc_fall_o <= 1'b0;
        end else begin
            mdc_rise_o <= 1'b0;
            mdc_fall_o <= 1'b0;

            if (half_cnt == CLKS_PER_HALF_MDC - 1) begin
                half_cnt <= '0;
                mdc_o <= !mdc_o;
                // Strobe lines up with the new MDC level
                mdc_rise_o <= !mdc_o;
                mdc_fall_o <= mdc_o;
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end
        end
    end

    a_strobes_exclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(mdc_rise_o && mdc_fall_o)
    );

endmodule

// ==== verilog/mdio_pkg.sv ====
package mdio_pkg;

    // MDC timing, kept short for simulation
    localparam int CLKS_PER_HALF_MDC = 4;

    // Clause 22 frame layout
    localparam int PREAMBLE_BITS = 32;
    localparam int FRAME_BITS = 32;

    localparam int MDIO_PHY_ADDR_W = 5;
    localparam int MDIO_REG_ADDR_W = 5;
    localparam int MDIO_DATA_W = 16;

    localparam logic [1:0] FRAME_START = 2'b01;
    localparam logic [1:0] OP_WRITE = 2'b01;
    localparam logic [1:0] OP_READ = 2'b10;
    localparam logic [1:0] TA_WRITE = 2'b10;
    localparam logic [1:0] TA_READ = 2'b11;

    // Bit positions inside the 32 bits that follow the preamble
    localparam int FRAME_TA_BIT = 4 + MDIO_PHY_ADDR_W + MDIO_REG_ADDR_W;
    localparam int FRAME_DATA_BIT = FRAME_TA_BIT + 2;

    // Init writes issued once after reset
    localparam int INIT_COUNT = 3;

    localparam logic [MDIO_PHY_ADDR_W-1:0] INIT_PHY [INIT_COUNT] = '{
        5'd1,
        5'd1,
        5'd1
    };

    localparam logic [MDIO_REG_ADDR_W-1:0] INIT_REG [INIT_COUNT] = '{
        5'h18,
        5'h00,
        5'h04
    };

    // LEDs off, autoneg enable with restart, advertise 10/100
    localparam logic [MDIO_DATA_W-1:0] INIT_DATA [INIT_COUNT] = '{
        16'h0018,
        16'h1200,
        16'h01e1
    };

endpackage
